//--- hw/dma_consts.svh
// *********************************************************************
// widths and burst sizing shared by the DMA packages and RTL
// include this wherever one of the macros below is used
// *********************************************************************

`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// byte address and beat data widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_BEAT_BYTES 4

// transfer length counted in beats
`define DMA_LEN_W 16

// longest INCR burst issued on AW or AR
`define DMA_BURST_BEATS 16

// AXI field widths
`define AXI_LEN_W 8
`define AXI_RESP_W 2

`endif

//--- hw/axi_pkg.sv
// *********************************************************************
// AXI4 master channel payloads used by the DMA
// only the fields this master drives or reads are carried; the
// sideband fields are fixed by the slave being full-width INCR
// *********************************************************************

`include "dma_consts.svh"

package axi_pkg;

   // address channel, shared by AW and AR
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`AXI_LEN_W-1:0]  len;
   } axi_ax_t;

   // write data, all byte lanes enabled
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } axi_w_t;

   // read data
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic [`AXI_RESP_W-1:0] resp;
      logic                   last;
   } axi_r_t;

   // write response
   typedef struct packed {
      logic [`AXI_RESP_W-1:0] resp;
   } axi_b_t;

endpackage

//--- hw/dma_pkg.sv
// *********************************************************************
// DMA side request, planner to engine burst command and the FSM
// state encodings of the planner and the write engine
// *********************************************************************

`include "dma_consts.svh"

package dma_pkg;

   // one transfer, len counts beats and is never zero
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_LEN_W-1:0]  len;
   } dma_req_t;

   // one burst, len is beats minus one as on AXI
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`AXI_LEN_W-1:0]  len;
   } burst_cmd_t;

   typedef enum logic [1:0] {
      pl_idle,
      pl_issue,
      pl_wait_end
   } planner_state_e;

   typedef enum logic [1:0] {
      ph_addr,
      ph_data,
      ph_resp
   } wr_phase_e;

endpackage

//--- hw/burst_planner.sv
// *********************************************************************
// splits one DMA request into INCR bursts of at most DMA_BURST_BEATS
// a rising edge on init starts it; one burst is in flight at a time
// and done rises once the engine has ended the final burst
// *********************************************************************

`timescale 1ns/1ns
`include "dma_consts.svh"

module burst_planner
   (
   input  logic                  m_axi_aclk,
   input  logic                  m_axi_aresetn,
   input  logic                  init,
   input  dma_pkg::dma_req_t     req,
   input  logic                  burst_end,
   output logic                  burst_valid,
   output dma_pkg::burst_cmd_t   burst_cmd,
   output logic                  done
   );

   logic                      init_d;
   logic                      init_dd;
   logic                      init_edge;
   dma_pkg::planner_state_e   state;
   logic [`DMA_ADDR_W-1:0]    cur_addr;
   logic [`DMA_LEN_W-1:0]     remaining;
   logic [`DMA_LEN_W-1:0]     burst_beats;

   // two-flop sample of the init level
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         init_d  <= 1'b0;
         init_dd <= 1'b0;
      end
      else
      begin
         init_d  <= init;
         init_dd <= init_d;
      end
   end

   assign init_edge = init_d & ~init_dd;

   // beats in the next burst
   assign burst_beats = (remaining < `DMA_LEN_W'(`DMA_BURST_BEATS)) ?
                        remaining : `DMA_LEN_W'(`DMA_BURST_BEATS);

   // *******************************************************************
   // burst sequencing
   // *******************************************************************
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         state       <= dma_pkg::pl_idle;
         cur_addr    <= '0;
         remaining   <= '0;
         burst_valid <= 1'b0;
         done        <= 1'b0;
      end
      else
      begin
         burst_valid <= 1'b0;
         case (state)
            dma_pkg::pl_idle:
            begin
               // private copy of the request for the whole transfer
               if (init_edge)
               begin
                  cur_addr  <= req.addr;
                  remaining <= req.len;
                  done      <= 1'b0;
                  state     <= dma_pkg::pl_issue;
               end
            end
            dma_pkg::pl_issue:
            begin
               burst_valid <= 1'b1;
               cur_addr    <= cur_addr + `DMA_ADDR_W'(`DMA_BURST_BEATS * `DMA_BEAT_BYTES);
               remaining   <= remaining - burst_beats;
               state       <= dma_pkg::pl_wait_end;
            end
            dma_pkg::pl_wait_end:
            begin
               if (burst_end)
               begin
                  if (remaining == '0)
                  begin
                     done  <= 1'b1;
                     state <= dma_pkg::pl_idle;
                  end
                  else
                  begin
                     state <= dma_pkg::pl_issue;
                  end
               end
            end
            default:
            begin
               state <= dma_pkg::pl_idle;
            end
         endcase
      end
   end

   // command payload, valid only with burst_valid
   always_ff @(posedge m_axi_aclk)
   begin
      if (state == dma_pkg::pl_issue)
      begin
         burst_cmd.addr <= cur_addr;
         burst_cmd.len  <= `AXI_LEN_W'(burst_beats - 1'b1);
      end
   end

endmodule

//--- hw/dma_write_engine.sv
// *********************************************************************
// write direction burst engine
// takes one burst command, presents AW, streams W straight from the
// local source and waits for B; burst_end pulses on B accepted
// *********************************************************************

`timescale 1ns/1ns
`include "dma_consts.svh"

module dma_write_engine
   (
   input  logic                     m_axi_aclk,
   input  logic                     m_axi_aresetn,
   input  logic                     burst_valid,
   input  dma_pkg::burst_cmd_t      burst_cmd,
   output logic                     burst_end,
   // aw
   output axi_pkg::axi_ax_t         m_axi_aw,
   output logic                     m_axi_awvalid,
   input  logic                     m_axi_awready,
   // w
   output axi_pkg::axi_w_t          m_axi_w,
   output logic                     m_axi_wvalid,
   input  logic                     m_axi_wready,
   // b
   input  axi_pkg::axi_b_t          m_axi_b,
   input  logic                     m_axi_bvalid,
   output logic                     m_axi_bready,
   // local source
   input  logic [`DMA_DATA_W-1:0]   wrdata,
   output logic                     wrready
   );

   logic                      active;
   dma_pkg::wr_phase_e        phase;
   logic [`AXI_LEN_W-1:0]     beat_cnt;
   logic                      aw_ack;
   logic                      w_ack;
   logic                      b_ack;

   // one handshake per phase, W only after AW
   assign m_axi_awvalid = active && (phase == dma_pkg::ph_addr);
   assign m_axi_wvalid  = active && (phase == dma_pkg::ph_data);
   assign m_axi_bready  = active && (phase == dma_pkg::ph_resp);

   assign aw_ack = m_axi_awvalid & m_axi_awready;
   assign w_ack  = m_axi_wvalid & m_axi_wready;
   assign b_ack  = m_axi_bvalid & m_axi_bready;

   // source word goes out as is, and advances on acceptance
   assign m_axi_w.data = wrdata;
   assign m_axi_w.last = (beat_cnt == m_axi_aw.len);
   assign wrready      = w_ack;

   // *******************************************************************
   // phase sequencer
   // *******************************************************************
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         active    <= 1'b0;
         phase     <= dma_pkg::ph_addr;
         beat_cnt  <= '0;
         burst_end <= 1'b0;
      end
      else
      begin
         burst_end <= 1'b0;
         if (!active)
         begin
            if (burst_valid)
            begin
               active   <= 1'b1;
               phase    <= dma_pkg::ph_addr;
               beat_cnt <= '0;
            end
         end
         else
         begin
            case (phase)
               dma_pkg::ph_addr:
               begin
                  if (aw_ack)
                     phase <= dma_pkg::ph_data;
               end
               dma_pkg::ph_data:
               begin
                  if (w_ack && m_axi_w.last)
                     phase <= dma_pkg::ph_resp;
                  else if (w_ack)
                     beat_cnt <= beat_cnt + 1'b1;
               end
               dma_pkg::ph_resp:
               begin
                  // response code is not checked
                  if (b_ack)
                  begin
                     active    <= 1'b0;
                     burst_end <= 1'b1;
                  end
               end
               default:
               begin
                  phase <= dma_pkg::ph_addr;
               end
            endcase
         end
      end
   end

   // AW payload held for the whole burst
   always_ff @(posedge m_axi_aclk)
   begin
      if (burst_valid && !active)
      begin
         m_axi_aw.addr <= burst_cmd.addr;
         m_axi_aw.len  <= burst_cmd.len;
      end
   end

endmodule

//--- hw/dma_read_engine.sv
// *********************************************************************
// read direction burst engine
// presents AR for one burst command, then takes R beats and strobes
// each one out to the local sink; burst_end pulses on the last beat
// *********************************************************************

`timescale 1ns/1ns
`include "dma_consts.svh"

module dma_read_engine
   (
   input  logic                     m_axi_aclk,
   input  logic                     m_axi_aresetn,
   input  logic                     burst_valid,
   input  dma_pkg::burst_cmd_t      burst_cmd,
   output logic                     burst_end,
   // ar
   output axi_pkg::axi_ax_t         m_axi_ar,
   output logic                     m_axi_arvalid,
   input  logic                     m_axi_arready,
   // r
   input  axi_pkg::axi_r_t          m_axi_r,
   input  logic                     m_axi_rvalid,
   output logic                     m_axi_rready,
   // local sink
   output logic [`DMA_DATA_W-1:0]   rddata,
   output logic                     rdvalid
   );

   logic ar_ack;
   logic r_ack;

   assign ar_ack = m_axi_arvalid & m_axi_arready;
   assign r_ack  = m_axi_rvalid & m_axi_rready;

   // every accepted beat goes to the sink
   assign rddata  = m_axi_r.data;
   assign rdvalid = r_ack;

   // *******************************************************************
   // AR then R
   // *******************************************************************
   always_ff @(posedge m_axi_aclk)
   begin
      if (!m_axi_aresetn)
      begin
         m_axi_arvalid <= 1'b0;
         m_axi_rready  <= 1'b0;
         burst_end     <= 1'b0;
      end
      else
      begin
         burst_end <= 1'b0;
         if (burst_valid && !m_axi_arvalid && !m_axi_rready)
         begin
            m_axi_arvalid <= 1'b1;
         end
         else if (ar_ack)
         begin
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b1;
         end
         else if (r_ack && m_axi_r.last)
         begin
            m_axi_rready <= 1'b0;
            burst_end    <= 1'b1;
         end
      end
   end

   // AR payload, stable while arvalid is high
   always_ff @(posedge m_axi_aclk)
   begin
      if (burst_valid && !m_axi_arvalid && !m_axi_rready)
      begin
         m_axi_ar.addr <= burst_cmd.addr;
         m_axi_ar.len  <= burst_cmd.len;
      end
   end

endmodule

//--- hw/axi_dma.sv
// *********************************************************************
// AXI4 burst DMA master, top level
// independent write and read directions, each a planner feeding
// an engine; start with a rising edge on dma_wrinit or dma_rdinit
// *********************************************************************

`timescale 1ns/1ns
`include "dma_consts.svh"

module axi_dma
   (
   input  logic                     m_axi_aclk,
   input  logic                     m_axi_aresetn,
   // aw
   output axi_pkg::axi_ax_t         m_axi_aw,
   output logic                     m_axi_awvalid,
   input  logic                     m_axi_awready,
   // w
   output axi_pkg::axi_w_t          m_axi_w,
   output logic                     m_axi_wvalid,
   input  logic                     m_axi_wready,
   // b
   input  axi_pkg::axi_b_t          m_axi_b,
   input  logic                     m_axi_bvalid,
   output logic                     m_axi_bready,
   // ar
   output axi_pkg::axi_ax_t         m_axi_ar,
   output logic                     m_axi_arvalid,
   input  logic                     m_axi_arready,
   // r
   input  axi_pkg::axi_r_t          m_axi_r,
   input  logic                     m_axi_rvalid,
   output logic                     m_axi_rready,
   // dma write side
   input  dma_pkg::dma_req_t        dma_wr_req,
   input  logic                     dma_wrinit,
   input  logic [`DMA_DATA_W-1:0]   dma_wrdata,
   output logic                     dma_wrready,
   output logic                     dma_wrdone,
   // dma read side
   input  dma_pkg::dma_req_t        dma_rd_req,
   input  logic                     dma_rdinit,
   output logic [`DMA_DATA_W-1:0]   dma_rddata,
   output logic                     dma_rdvalid,
   output logic                     dma_rddone
   );

   logic                  wr_burst_valid;
   dma_pkg::burst_cmd_t   wr_burst_cmd;
   logic                  wr_burst_end;
   logic                  rd_burst_valid;
   dma_pkg::burst_cmd_t   rd_burst_cmd;
   logic                  rd_burst_end;

   // *******************************************************************
   // write direction
   // *******************************************************************
   burst_planner u_wr_planner
      (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .init          (dma_wrinit),
      .req           (dma_wr_req),
      .burst_end     (wr_burst_end),
      .burst_valid   (wr_burst_valid),
      .burst_cmd     (wr_burst_cmd),
      .done          (dma_wrdone)
      );

   dma_write_engine u_wr_engine
      (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .burst_valid   (wr_burst_valid),
      .burst_cmd     (wr_burst_cmd),
      .burst_end     (wr_burst_end),
      .m_axi_aw      (m_axi_aw),
      .m_axi_awvalid (m_axi_awvalid),
      .m_axi_awready (m_axi_awready),
      .m_axi_w       (m_axi_w),
      .m_axi_wvalid  (m_axi_wvalid),
      .m_axi_wready  (m_axi_wready),
      .m_axi_b       (m_axi_b),
      .m_axi_bvalid  (m_axi_bvalid),
      .m_axi_bready  (m_axi_bready),
      .wrdata        (dma_wrdata),
      .wrready       (dma_wrready)
      );

   // *******************************************************************
   // read direction
   // *******************************************************************
   burst_planner u_rd_planner
      (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .init          (dma_rdinit),
      .req           (dma_rd_req),
      .burst_end     (rd_burst_end),
      .burst_valid   (rd_burst_valid),
      .burst_cmd     (rd_burst_cmd),
      .done          (dma_rddone)
      );

   dma_read_engine u_rd_engine
      (
      .m_axi_aclk    (m_axi_aclk),
      .m_axi_aresetn (m_axi_aresetn),
      .burst_valid   (rd_burst_valid),
      .burst_cmd     (rd_burst_cmd),
      .burst_end     (rd_burst_end),
      .m_axi_ar      (m_axi_ar),
      .m_axi_arvalid (m_axi_arvalid),
      .m_axi_arready (m_axi_arready),
      .m_axi_r       (m_axi_r),
      .m_axi_rvalid  (m_axi_rvalid),
      .m_axi_rready  (m_axi_rready),
      .rddata        (dma_rddata),
      .rdvalid       (dma_rdvalid)
      );

endmodule

//--- tests/axi_dma_tb.sv
// *********************************************************************
// directed testbench for the AXI4 burst DMA master
// an AXI slave memory model checks every burst against the burst rule,
// a local source feeds W and a local sink checks the read stream
// *********************************************************************

`timescale 1ns/1ns
`include "dma_consts.svh"

module axi_dma_tb;

   localparam int wait_limit = 2000;

   logic                      m_axi_aclk;
   logic                      m_axi_aresetn;
   axi_pkg::axi_ax_t          m_axi_aw;
   logic                      m_axi_awvalid;
   logic                      m_axi_awready;
   axi_pkg::axi_w_t           m_axi_w;
   logic                      m_axi_wvalid;
   logic                      m_axi_wready;
   axi_pkg::axi_b_t           m_axi_b;
   logic                      m_axi_bvalid;
   logic                      m_axi_bready;
   axi_pkg::axi_ax_t          m_axi_ar;
   logic                      m_axi_arvalid;
   logic                      m_axi_arready;
   axi_pkg::axi_r_t           m_axi_r;
   logic                      m_axi_rvalid;
   logic                      m_axi_rready;
   dma_pkg::dma_req_t         dma_wr_req;
   logic                      dma_wrinit;
   logic [`DMA_DATA_W-1:0]    dma_wrdata;
   logic                      dma_wrready;
   logic                      dma_wrdone;
   dma_pkg::dma_req_t         dma_rd_req;
   logic                      dma_rdinit;
   logic [`DMA_DATA_W-1:0]    dma_rddata;
   logic                      dma_rdvalid;
   logic                      dma_rddone;

   integer        seed;
   integer        i;
   string         test_name;
   logic          stall_en;
   logic [31:0]   mem [0:1023];
   logic [31:0]   ref_mem [0:1023];
   logic [31:0]   src [0:63];
   // expected burst sequence and progress per direction
   logic [31:0]   wr_base;
   logic [31:0]   wr_exp_addr;
   integer        wr_left;
   integer        wr_bursts;
   integer        wr_idx;
   logic [31:0]   rd_base;
   logic [31:0]   rd_exp_addr;
   integer        rd_left;
   integer        rd_bursts;
   integer        rd_cnt;
   integer        rd_len;
   // slave model state
   axi_pkg::axi_ax_t aw_s;
   axi_pkg::axi_ax_t ar_s;
   axi_pkg::axi_w_t  w_s;
   logic          aw_hs;
   logic          w_hs;
   logic          b_hs;
   logic          ar_hs;
   logic          r_hs;
   logic          wr_adv;
   logic [31:0]   w_base;
   logic [31:0]   r_base;
   logic [7:0]    w_len;
   logic [7:0]    r_len;
   integer        w_beat;
   integer        r_beat;
   logic          b_pend;
   logic          r_active;

   axi_dma dut0 (.*);

   // local write source
   assign dma_wrdata = src[wr_idx];

   always #50 m_axi_aclk = ~m_axi_aclk;

   // *******************************************************************
   // checking helpers
   // *******************************************************************
   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check(input string what, input logic [63:0] expv, input logic [63:0] actv);
      if (expv !== actv)
      begin
         $display("error %s %s: expected %0h actual %0h", test_name, what, expv, actv);
         abort_run();
      end
   endtask

   // one AW or AR against the next burst of the request
   task automatic check_burst(input string what, input axi_pkg::axi_ax_t ax,
                              inout logic [31:0] exp_addr, inout integer left,
                              inout integer bursts);
      integer beats;
      beats = (left < `DMA_BURST_BEATS) ? left : `DMA_BURST_BEATS;
      check({what, " addr"}, exp_addr, ax.addr);
      check({what, " len"}, beats - 1, ax.len);
      exp_addr = exp_addr + `DMA_BURST_BEATS * `DMA_BEAT_BYTES;
      left = left - beats;
      bursts = bursts + 1;
   endtask

   // ready and valid stall on 1 in 4 cycles when enabled
   function automatic logic coin();
      integer r;
      r = $random(seed);
      return !stall_en || (r[1:0] != 2'b00);
   endfunction

   task automatic wait_done(input logic rd, input logic level);
      integer n;
      n = 0;
      while (((rd ? dma_rddone : dma_wrdone) !== level) && (n < wait_limit))
      begin
         @(negedge m_axi_aclk);
         n = n + 1;
      end
      if ((rd ? dma_rddone : dma_wrdone) !== level)
      begin
         $display("timeout in %s: %s done never went %s", test_name,
                  rd ? "read" : "write", level ? "high" : "low");
         abort_run();
      end
   endtask

   // *******************************************************************
   // AXI slave memory model and read sink
   // *******************************************************************
   always
   begin
      @(negedge m_axi_aclk);
      aw_s   = m_axi_aw;
      w_s    = m_axi_w;
      ar_s   = m_axi_ar;
      aw_hs  = m_axi_awvalid & m_axi_awready;
      w_hs   = m_axi_wvalid & m_axi_wready;
      b_hs   = m_axi_bvalid & m_axi_bready;
      ar_hs  = m_axi_arvalid & m_axi_arready;
      r_hs   = m_axi_rvalid & m_axi_rready;
      wr_adv = dma_wrready;
      check("wrready strobe", w_hs, dma_wrready);
      check("rdvalid strobe", r_hs, dma_rdvalid);
      if (dma_rdvalid === 1'b1)
      begin
         check("rd beat count", 1, rd_cnt < rd_len);
         check("rd data", ref_mem[(rd_base >> 2) + rd_cnt], dma_rddata);
         rd_cnt = rd_cnt + 1;
      end
      @(posedge m_axi_aclk);
      #1;
      if (!m_axi_aresetn)
      begin
         m_axi_awready = 1'b0;
         m_axi_wready  = 1'b0;
         m_axi_bvalid  = 1'b0;
         m_axi_arready = 1'b0;
         m_axi_rvalid  = 1'b0;
         b_pend        = 1'b0;
         r_active      = 1'b0;
      end
      else
      begin
         if (aw_hs)
         begin
            check_burst("aw", aw_s, wr_exp_addr, wr_left, wr_bursts);
            w_base = aw_s.addr;
            w_len  = aw_s.len;
            w_beat = 0;
         end
         if (w_hs)
         begin
            check("wlast", w_beat == w_len, w_s.last);
            mem[(w_base >> 2) + w_beat] = w_s.data;
            w_beat = w_beat + 1;
            if (w_s.last)
               b_pend = 1'b1;
         end
         if (wr_adv)
            wr_idx = wr_idx + 1;
         if (b_hs)
            m_axi_bvalid = 1'b0;
         if (b_pend && !m_axi_bvalid && coin())
         begin
            m_axi_bvalid = 1'b1;
            b_pend       = 1'b0;
         end
         if (ar_hs)
         begin
            check_burst("ar", ar_s, rd_exp_addr, rd_left, rd_bursts);
            r_base   = ar_s.addr;
            r_len    = ar_s.len;
            r_beat   = 0;
            r_active = 1'b1;
         end
         if (r_hs)
         begin
            if (r_beat == r_len)
               r_active = 1'b0;
            r_beat = r_beat + 1;
         end
         // valid and payload only move when idle or just accepted
         if (!r_active)
            m_axi_rvalid = 1'b0;
         else if (!m_axi_rvalid || r_hs)
         begin
            m_axi_rvalid = coin();
            m_axi_r.data = mem[(r_base >> 2) + r_beat];
            m_axi_r.resp = 2'b00;
            m_axi_r.last = (r_beat == r_len);
         end
         m_axi_awready = coin();
         m_axi_wready  = coin();
         m_axi_arready = coin();
      end
   end

   // *******************************************************************
   // transfer tasks
   // *******************************************************************
   task automatic start_write(input logic [31:0] addr, input integer len);
      integer k;
      for (k = 0; k < len; k = k + 1)
         src[k] = $random(seed);
      wr_idx          = 0;
      wr_base         = addr;
      wr_exp_addr     = addr;
      wr_left         = len;
      wr_bursts       = 0;
      dma_wr_req.addr = addr;
      dma_wr_req.len  = len;
      dma_wrinit      = 1'b1;
   endtask

   task automatic start_read(input logic [31:0] addr, input integer len);
      rd_cnt          = 0;
      rd_len          = len;
      rd_base         = addr;
      rd_exp_addr     = addr;
      rd_left         = len;
      rd_bursts       = 0;
      dma_rd_req.addr = addr;
      dma_rd_req.len  = len;
      dma_rdinit      = 1'b1;
   endtask

   task automatic finish_write(input integer len, input integer bursts);
      integer k;
      check("write bursts", bursts, wr_bursts);
      check("source words taken", len, wr_idx);
      for (k = 0; k < len; k = k + 1)
      begin
         check("memory word", src[k], mem[(wr_base >> 2) + k]);
         ref_mem[(wr_base >> 2) + k] = src[k];
      end
      @(posedge m_axi_aclk);
      #1;
      dma_wrinit = 1'b0;
      repeat (3) @(posedge m_axi_aclk);
   endtask

   task automatic finish_read(input integer len, input integer bursts);
      check("read bursts", bursts, rd_bursts);
      check("read beats", len, rd_cnt);
      @(posedge m_axi_aclk);
      #1;
      dma_rdinit = 1'b0;
      repeat (3) @(posedge m_axi_aclk);
   endtask

   task automatic run_write(input logic [31:0] addr, input integer len, input integer bursts);
      @(posedge m_axi_aclk);
      #1;
      start_write(addr, len);
      wait_done(1'b0, 1'b0);
      wait_done(1'b0, 1'b1);
      finish_write(len, bursts);
   endtask

   task automatic run_read(input logic [31:0] addr, input integer len, input integer bursts);
      @(posedge m_axi_aclk);
      #1;
      start_read(addr, len);
      wait_done(1'b1, 1'b0);
      wait_done(1'b1, 1'b1);
      finish_read(len, bursts);
   endtask

   // *******************************************************************
   // directed tests
   // *******************************************************************
   task automatic test_reset_state();
      test_name = "reset_state";
      @(negedge m_axi_aclk);
      check("awvalid", 0, m_axi_awvalid);
      check("wvalid", 0, m_axi_wvalid);
      check("bready", 0, m_axi_bready);
      check("arvalid", 0, m_axi_arvalid);
      check("rready", 0, m_axi_rready);
      check("wrready", 0, dma_wrready);
      check("rdvalid", 0, dma_rdvalid);
      check("wrdone", 0, dma_wrdone);
      check("rddone", 0, dma_rddone);
   endtask

   task automatic test_write_short();
      test_name = "write_short";
      run_write(32'h0000_0100, 5, 1);
   endtask

   task automatic test_write_multi();
      test_name = "write_multi";
      stall_en  = 1'b1;
      run_write(32'h0000_0200, 37, 3);
   endtask

   // tail of write_multi plus fresh words
   task automatic test_read_multi();
      test_name = "read_multi";
      run_read(32'h0000_0280, 20, 2);
   endtask

   task automatic test_concurrent();
      test_name = "concurrent";
      @(posedge m_axi_aclk);
      #1;
      start_write(32'h0000_0400, 24);
      start_read(32'h0000_00f8, 9);
      wait_done(1'b0, 1'b0);
      wait_done(1'b1, 1'b0);
      wait_done(1'b0, 1'b1);
      wait_done(1'b1, 1'b1);
      finish_write(24, 2);
      finish_read(9, 1);
   endtask

   task automatic test_restart();
      test_name = "restart";
      run_write(32'h0000_0800, 17, 2);
      check("wrdone before restart", 1, dma_wrdone);
      run_write(32'h0000_0900, 3, 1);
   endtask

   // *******************************************************************
   // test sequence
   // *******************************************************************
   initial
   begin
      seed          = 32'h572e_1988;
      m_axi_aclk    = 1'b0;
      m_axi_aresetn = 1'b0;
      m_axi_awready = 1'b0;
      m_axi_wready  = 1'b0;
      m_axi_b       = '0;
      m_axi_bvalid  = 1'b0;
      m_axi_arready = 1'b0;
      m_axi_r       = '0;
      m_axi_rvalid  = 1'b0;
      dma_wr_req    = '0;
      dma_wrinit    = 1'b0;
      dma_rd_req    = '0;
      dma_rdinit    = 1'b0;
      stall_en      = 1'b0;
      wr_idx        = 0;
      wr_left       = 0;
      wr_bursts     = 0;
      rd_cnt        = 0;
      rd_len        = 0;
      rd_left       = 0;
      rd_bursts     = 0;
      rd_base       = '0;
      // unwritten words read back as their address scrambled
      for (i = 0; i < 1024; i = i + 1)
      begin
         mem[i]     = (i * 4) ^ 32'hA5A5_5A5A;
         ref_mem[i] = (i * 4) ^ 32'hA5A5_5A5A;
      end
      for (i = 0; i < 64; i = i + 1)
         src[i] = '0;
      repeat (16) @(posedge m_axi_aclk);
      #1;
      m_axi_aresetn = 1'b1;

      test_reset_state();
      test_write_short();
      test_write_multi();
      test_read_multi();
      test_concurrent();
      test_restart();

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- files.f
+incdir+hw
hw/axi_pkg.sv
hw/dma_pkg.sv
hw/burst_planner.sv
hw/dma_write_engine.sv
hw/dma_read_engine.sv
hw/axi_dma.sv
tests/axi_dma_tb.sv

//--- Bender.yml
package:
  name: axi_dma

sources:
  - include_dirs:
      - hw
    files:
      - hw/axi_pkg.sv
      - hw/dma_pkg.sv
      - hw/burst_planner.sv
      - hw/dma_write_engine.sv
      - hw/dma_read_engine.sv
      - hw/axi_dma.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/axi_dma_tb.sv
